// ==== src/lsu_defs.svh ====
// size macros for the load/store pipeline: ways, sets, store buffer depth, translation entries
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// cache organization
// 16 sets of 4-word lines puts the set index at address bits 7..4
`define LSU_WAYS 4
`define LSU_SETS 16

// pending stores between handoff and commit
`define LSU_SB_DEPTH 4

// fully associative translation table
`define LSU_TLB_ENTRIES 8

`endif

// ==== src/lsu_pkg.sv ====
// address union, exception enum and store buffer entry type
`default_nettype none

package lsu_pkg;

    // page view, used by translation
    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] off;
    } lsu_page_view_t;

    // cache view, used by the arrays and forwarding
    typedef struct packed {
        logic [23:0] tag;
        logic [3:0]  set;
        logic [1:0]  word;
        logic [1:0]  boff;
    } lsu_cache_view_t;

    typedef union packed {
        lsu_page_view_t  page;
        lsu_cache_view_t cache;
    } lsu_addr_u;

    // listed in priority order after none
    typedef enum logic [1:0] {
        EXCP_NONE,
        EXCP_ALE,  // misaligned
        EXCP_TLBR, // no translation
        EXCP_PME   // store to a clean page
    } lsu_excp_e;

    typedef struct packed {
        logic [29:0] waddr; // physical word address
        logic [1:0]  way;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } lsu_sb_entry_t;

endpackage

`default_nettype wire

// ==== src/lsu_stage_if.sv ====
// m1-to-m2 handoff interface with m1 and m2 modports
`default_nettype none

interface lsu_stage_if import lsu_pkg::*; ();

    logic        valid;
    logic        ready;
    logic [31:0] rdata; // load word after forwarding
    logic        hit;
    lsu_excp_e   excp;

    modport m1 (
        output valid, rdata, hit, excp,
        input  ready
    );

    modport m2 (
        input  valid, rdata, hit, excp,
        output ready
    );

endinterface

`default_nettype wire

// ==== src/lsu_addr_trans.sv ====
// fully associative translation table with update port and combinational lookup
`default_nettype none
`include "lsu_defs.svh"

module lsu_addr_trans (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tlb_we_i,
    input  logic [2:0]  tlb_idx_i,
    input  logic [19:0] tlb_vpn_i,
    input  logic [19:0] tlb_ppn_i,
    input  logic        tlb_v_i,
    input  logic        tlb_d_i,
    input  logic [19:0] vpn_i,
    output logic        found_o,
    output logic [19:0] ppn_o,
    output logic        valid_o,
    output logic        dirty_o
);

    logic [`LSU_TLB_ENTRIES-1:0] used_q; // entry written since reset
    logic [19:0] vpn_q [`LSU_TLB_ENTRIES];
    logic [19:0] ppn_q [`LSU_TLB_ENTRIES];
    logic [`LSU_TLB_ENTRIES-1:0] v_q;
    logic [`LSU_TLB_ENTRIES-1:0] d_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            used_q <= '0;
        end else if (tlb_we_i) begin
            used_q[tlb_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we_i) begin
            vpn_q[tlb_idx_i] <= tlb_vpn_i;
            ppn_q[tlb_idx_i] <= tlb_ppn_i;
            v_q[tlb_idx_i]   <= tlb_v_i;
            d_q[tlb_idx_i]   <= tlb_d_i;
        end
    end

    // scan from the top so the lowest matching index is the last one kept
    always_comb begin
        found_o = 1'b0;
        ppn_o   = '0;
        valid_o = 1'b0;
        dirty_o = 1'b0;
        for (int i = `LSU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (used_q[i] && vpn_q[i] == vpn_i) begin
                found_o = 1'b1;
                ppn_o   = ppn_q[i];
                valid_o = v_q[i];
                dirty_o = d_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu_cache_array.sv ====
// tag and data arrays with synchronous read, line fill and committed byte write
`default_nettype none
`include "lsu_defs.svh"

module lsu_cache_array (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [3:0]                         rd_set_i,
    output logic [`LSU_WAYS-1:0][23:0]         rd_tag_o,
    output logic [`LSU_WAYS-1:0]               rd_valid_o,
    output logic [`LSU_WAYS-1:0][3:0][31:0]    rd_data_o,
    input  logic                               fill_valid_i,
    input  logic [3:0]                         fill_set_i,
    input  logic [1:0]                         fill_way_i,
    input  logic [23:0]                        fill_tag_i,
    input  logic [3:0][31:0]                   fill_data_i,
    input  logic                               wr_valid_i,
    input  logic [1:0]                         wr_way_i,
    input  logic [3:0]                         wr_set_i,
    input  logic [1:0]                         wr_word_i,
    input  logic [3:0]                         wr_strb_i,
    input  logic [31:0]                        wr_data_i
);

    logic [23:0]      tag_q  [`LSU_WAYS][`LSU_SETS];
    logic [3:0][31:0] data_q [`LSU_WAYS][`LSU_SETS];
    logic [`LSU_WAYS-1:0][`LSU_SETS-1:0] vld_q;

    logic [`LSU_WAYS-1:0][23:0]      rd_tag_n;
    logic [`LSU_WAYS-1:0]            rd_valid_n;
    logic [`LSU_WAYS-1:0][3:0][31:0] rd_data_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (fill_valid_i) begin
            vld_q[fill_way_i][fill_set_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            tag_q[fill_way_i][fill_set_i]  <= fill_tag_i;
            data_q[fill_way_i][fill_set_i] <= fill_data_i;
        end
        if (wr_valid_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb_i[b]) begin
                    data_q[wr_way_i][wr_set_i][wr_word_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // read sees a write to the same set on the same edge
    always_comb begin
        for (int w = 0; w < `LSU_WAYS; w++) begin
            rd_tag_n[w]   = tag_q[w][rd_set_i];
            rd_valid_n[w] = vld_q[w][rd_set_i];
            rd_data_n[w]  = data_q[w][rd_set_i];
        end
        if (fill_valid_i && fill_set_i == rd_set_i) begin
            rd_tag_n[fill_way_i]   = fill_tag_i;
            rd_valid_n[fill_way_i] = 1'b1;
            rd_data_n[fill_way_i]  = fill_data_i;
        end
        if (wr_valid_i && wr_set_i == rd_set_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb_i[b]) begin
                    rd_data_n[wr_way_i][wr_word_i][8*b +: 8] = wr_data_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_o <= '0;
        end else begin
            rd_valid_o <= rd_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_o  <= rd_tag_n;
        rd_data_o <= rd_data_n;
    end

    // refill and store drain never share an edge
    a_no_fill_and_drain: assert property (
        @(posedge clk) disable iff (!rst_n) !(fill_valid_i && wr_valid_i)
    );

endmodule

`default_nettype wire

// ==== src/lsu_m1_stage.sv ====
// m1 stage: request register, skid, exception checks, tag compare, store forwarding and push
`default_nettype none
`include "lsu_defs.svh"

module lsu_m1_stage import lsu_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  lsu_addr_u                           req_vaddr_i,
    input  logic [31:0]                         req_wdata_i,
    input  logic [3:0]                          req_strb_i,
    input  logic [1:0]                          req_size_i,
    output logic [3:0]                          rd_set_o,
    input  logic [`LSU_WAYS-1:0][23:0]          rd_tag_i,
    input  logic [`LSU_WAYS-1:0]                rd_valid_i,
    input  logic [`LSU_WAYS-1:0][3:0][31:0]     rd_data_i,
    output logic [19:0]                         vpn_o,
    input  logic                                tlb_found_i,
    input  logic [19:0]                         tlb_ppn_i,
    input  logic                                tlb_valid_i,
    input  logic                                tlb_dirty_i,
    input  lsu_sb_entry_t [`LSU_SB_DEPTH-1:0]   sb_entry_i,
    input  logic [`LSU_SB_DEPTH-1:0]            sb_valid_i,
    input  logic                                sb_full_i,
    output logic                                sb_push_o,
    output lsu_sb_entry_t                       sb_entry_o,
    lsu_stage_if.m1                             out_if
);

    logic        m1_valid_q, skid_valid_q;
    lsu_addr_u   m1_vaddr_q, skid_vaddr_q, act_vaddr, paddr;
    logic [31:0] m1_wdata_q, skid_wdata_q, act_wdata;
    logic [3:0]  m1_strb_q, skid_strb_q, act_strb;
    logic [1:0]  m1_size_q, skid_size_q, act_size;
    logic        act_valid, stall, handoff, store_ok, ale;
    logic [29:0] waddr;
    logic [`LSU_WAYS-1:0] way_hit;
    logic [1:0]  hit_way;
    logic [31:0] word;
    lsu_excp_e   excp;

    assign req_ready_o = !skid_valid_q;
    assign stall       = act_valid && !handoff;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid_q   <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (flush_i) begin
            m1_valid_q   <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            if (!skid_valid_q) m1_valid_q <= req_valid_i;
            skid_valid_q <= stall; // fills from m1 or holds itself
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_valid_q) begin
            m1_vaddr_q <= req_vaddr_i;
            m1_wdata_q <= req_wdata_i;
            m1_strb_q  <= req_strb_i;
            m1_size_q  <= req_size_i;
            if (stall) begin // m1 request parks in the skid
                skid_vaddr_q <= m1_vaddr_q;
                skid_wdata_q <= m1_wdata_q;
                skid_strb_q  <= m1_strb_q;
                skid_size_q  <= m1_size_q;
            end
        end
    end

    // index of whichever request is active next cycle
    assign rd_set_o = skid_valid_q ? (stall ? skid_vaddr_q.cache.set : m1_vaddr_q.cache.set)
                                   : (stall ? m1_vaddr_q.cache.set : req_vaddr_i.cache.set);

    assign act_valid = skid_valid_q | m1_valid_q;
    assign act_vaddr = skid_valid_q ? skid_vaddr_q : m1_vaddr_q;
    assign act_wdata = skid_valid_q ? skid_wdata_q : m1_wdata_q;
    assign act_strb  = skid_valid_q ? skid_strb_q  : m1_strb_q;
    assign act_size  = skid_valid_q ? skid_size_q  : m1_size_q;

    assign vpn_o = act_vaddr.page.vpn;
    assign paddr = lsu_addr_u'({tlb_ppn_i, act_vaddr.page.off});
    assign waddr = {paddr.cache.tag, paddr.cache.set, paddr.cache.word};

    assign ale = (act_size == 2'd0) ? 1'b0 :
                 (act_size == 2'd1) ? act_vaddr.cache.boff[0] : |act_vaddr.cache.boff;

    always_comb begin
        if (ale)                              excp = EXCP_ALE;
        else if (!(tlb_found_i && tlb_valid_i)) excp = EXCP_TLBR;
        else if (|act_strb && !tlb_dirty_i)   excp = EXCP_PME;
        else                                  excp = EXCP_NONE;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `LSU_WAYS; w++) begin
            way_hit[w] = rd_valid_i[w] && rd_tag_i[w] == paddr.cache.tag;
            if (way_hit[w]) hit_way = 2'(w);
        end
    end

    // buffered bytes overlay the cache word, youngest last
    always_comb begin
        word = rd_data_i[hit_way][paddr.cache.word];
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            if (sb_valid_i[i] && sb_entry_i[i].waddr == waddr) begin
                for (int b = 0; b < 4; b++) begin
                    if (sb_entry_i[i].strb[b]) begin
                        word[8*b +: 8] = sb_entry_i[i].wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign store_ok     = |act_strb && |way_hit && excp == EXCP_NONE;
    assign out_if.valid = act_valid && !(store_ok && sb_full_i); // wait for a free entry
    assign out_if.rdata = word;
    assign out_if.hit   = |way_hit && excp == EXCP_NONE;
    assign out_if.excp  = excp;
    assign handoff      = out_if.valid && out_if.ready;

    assign sb_push_o        = handoff && store_ok;
    assign sb_entry_o.waddr = waddr;
    assign sb_entry_o.way   = hit_way;
    assign sb_entry_o.strb  = act_strb;
    assign sb_entry_o.wdata = act_wdata;

endmodule

`default_nettype wire

// ==== src/lsu_store_buffer.sv ====
// store buffer: in-order queue with forwarding view, commit drain and flush
`default_nettype none
`include "lsu_defs.svh"

module lsu_store_buffer import lsu_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush_i,
    input  logic                               push_i,
    input  lsu_sb_entry_t                      entry_i,
    input  logic                               commit_i,
    output lsu_sb_entry_t [`LSU_SB_DEPTH-1:0]  entry_o,
    output logic [`LSU_SB_DEPTH-1:0]           valid_o,
    output logic                               full_o,
    output logic                               wr_valid_o,
    output logic [1:0]                         wr_way_o,
    output logic [3:0]                         wr_set_o,
    output logic [1:0]                         wr_word_o,
    output logic [3:0]                         wr_strb_o,
    output logic [31:0]                        wr_data_o
);

    localparam int PW = $clog2(`LSU_SB_DEPTH);

    lsu_sb_entry_t mem_q [`LSU_SB_DEPTH];
    logic [PW-1:0] head_q, tail_q;
    logic [PW:0]   count_q;
    logic          pop;

    assign pop    = commit_i && count_q != '0; // empty commit is ignored
    assign full_o = count_q == (PW+1)'(`LSU_SB_DEPTH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) tail_q <= tail_q + 1'b1;
            if (pop) head_q <= head_q + 1'b1;
            count_q <= count_q + (PW+1)'(push_i) - (PW+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem_q[tail_q] <= entry_i;
    end

    // slot 0 is the oldest store
    always_comb begin
        logic [PW-1:0] idx;
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            idx        = head_q + PW'(i);
            entry_o[i] = mem_q[idx];
            valid_o[i] = (PW+1)'(i) < count_q;
        end
    end

    assign wr_valid_o = pop;
    assign wr_way_o   = mem_q[head_q].way;
    assign wr_set_o   = mem_q[head_q].waddr[5:2];
    assign wr_word_o  = mem_q[head_q].waddr[1:0];
    assign wr_strb_o  = mem_q[head_q].strb;
    assign wr_data_o  = mem_q[head_q].wdata;

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
    );

endmodule

`default_nettype wire

// ==== src/lsu_m2_stage.sv ====
// m2 stage: result register, response handshake and back-pressure to m1
`default_nettype none

module lsu_m2_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    lsu_stage_if.m2     in_if,
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output logic [31:0] resp_rdata_o,
    output logic        resp_hit_o,
    output lsu_excp_e   resp_excp_o
);

    logic        valid_q;
    logic [31:0] rdata_q;
    logic        hit_q;
    lsu_excp_e   excp_q;

    // free slot, or the held result leaves this cycle
    assign in_if.ready = !valid_q || resp_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_if.ready) begin
            valid_q <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_if.ready && in_if.valid) begin
            rdata_q <= in_if.rdata;
            hit_q   <= in_if.hit;
            excp_q  <= in_if.excp;
        end
    end

    assign resp_valid_o = valid_q;
    assign resp_rdata_o = rdata_q;
    assign resp_hit_o   = hit_q;
    assign resp_excp_o  = excp_q;

    // a stalled response holds until taken
    a_resp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (resp_valid_o && !resp_ready_i && !flush_i) |=>
            (resp_valid_o && $stable(resp_rdata_o) && $stable(resp_hit_o)
             && $stable(resp_excp_o))
    );

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
// top level of the load/store pipeline with plain ports
`default_nettype none
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush_i,
    input  logic             commit_i,
    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  logic [31:0]      req_vaddr_i,
    input  logic [31:0]      req_wdata_i,
    input  logic [3:0]       req_strb_i,  // zero for loads
    input  logic [1:0]       req_size_i,
    output logic             resp_valid_o,
    input  logic             resp_ready_i,
    output logic [31:0]      resp_rdata_o,
    output logic             resp_hit_o,
    output lsu_excp_e        resp_excp_o,
    input  logic             fill_valid_i,
    input  logic [3:0]       fill_set_i,
    input  logic [1:0]       fill_way_i,
    input  logic [23:0]      fill_tag_i,
    input  logic [3:0][31:0] fill_data_i,
    input  logic             tlb_we_i,
    input  logic [2:0]       tlb_idx_i,
    input  logic [19:0]      tlb_vpn_i,
    input  logic [19:0]      tlb_ppn_i,
    input  logic             tlb_v_i,
    input  logic             tlb_d_i
);

    logic [3:0]                      rd_set;
    logic [`LSU_WAYS-1:0][23:0]      rd_tag;
    logic [`LSU_WAYS-1:0]            rd_valid;
    logic [`LSU_WAYS-1:0][3:0][31:0] rd_data;
    logic [19:0]                     vpn, ppn;
    logic                            found, pg_valid, pg_dirty;
    lsu_sb_entry_t [`LSU_SB_DEPTH-1:0] sb_entry;
    logic [`LSU_SB_DEPTH-1:0]        sb_valid;
    logic                            sb_full, sb_push;
    lsu_sb_entry_t                   sb_push_entry;
    logic                            wr_valid;
    logic [1:0]                      wr_way, wr_word;
    logic [3:0]                      wr_set, wr_strb;
    logic [31:0]                     wr_data;

    lsu_stage_if stage_if ();

    lsu_addr_trans trans_i (
        .clk, .rst_n, .tlb_we_i, .tlb_idx_i, .tlb_vpn_i, .tlb_ppn_i, .tlb_v_i, .tlb_d_i,
        .vpn_i(vpn), .found_o(found), .ppn_o(ppn), .valid_o(pg_valid), .dirty_o(pg_dirty)
    );

    lsu_cache_array array_i (
        .clk, .rst_n,
        .rd_set_i(rd_set), .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_data_o(rd_data),
        .fill_valid_i, .fill_set_i, .fill_way_i, .fill_tag_i, .fill_data_i,
        .wr_valid_i(wr_valid), .wr_way_i(wr_way), .wr_set_i(wr_set), .wr_word_i(wr_word),
        .wr_strb_i(wr_strb), .wr_data_i(wr_data)
    );

    lsu_m1_stage m1_i (
        .clk, .rst_n, .flush_i, .req_valid_i, .req_ready_o,
        .req_vaddr_i(lsu_addr_u'(req_vaddr_i)), .req_wdata_i, .req_strb_i, .req_size_i,
        .rd_set_o(rd_set), .rd_tag_i(rd_tag), .rd_valid_i(rd_valid), .rd_data_i(rd_data),
        .vpn_o(vpn), .tlb_found_i(found), .tlb_ppn_i(ppn),
        .tlb_valid_i(pg_valid), .tlb_dirty_i(pg_dirty),
        .sb_entry_i(sb_entry), .sb_valid_i(sb_valid), .sb_full_i(sb_full),
        .sb_push_o(sb_push), .sb_entry_o(sb_push_entry), .out_if(stage_if.m1)
    );

    lsu_store_buffer sb_i (
        .clk, .rst_n, .flush_i, .push_i(sb_push), .entry_i(sb_push_entry), .commit_i,
        .entry_o(sb_entry), .valid_o(sb_valid), .full_o(sb_full),
        .wr_valid_o(wr_valid), .wr_way_o(wr_way), .wr_set_o(wr_set), .wr_word_o(wr_word),
        .wr_strb_o(wr_strb), .wr_data_o(wr_data)
    );

    lsu_m2_stage m2_i (
        .clk, .rst_n, .flush_i, .in_if(stage_if.m2),
        .resp_valid_o, .resp_ready_i, .resp_rdata_o, .resp_hit_o, .resp_excp_o
    );

endmodule

`default_nettype wire

// ==== tb/lsu_tb.sv ====
// testbench for the load/store pipeline: stimulus table, random response stalls, checker
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int LIMIT      = 64;   // cycles allowed for one wait
    localparam int MAX_ROWS   = 64;
    localparam int MAX_CYCLES = 4000;

    typedef enum logic [2:0] {
        OP_TLB, OP_FILL, OP_LOAD, OP_STORE, OP_COMMIT, OP_FLUSH, OP_IDLE
    } op_e;

    typedef struct packed {
        op_e         kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  size;
        logic        exp_hit;
        lsu_excp_e   exp_excp;
        logic [31:0] exp_rdata;
    } row_t;

    logic             clk, rst_n, flush_i, commit_i;
    logic             req_valid_i, req_ready_o;
    logic [31:0]      req_vaddr_i, req_wdata_i;
    logic [3:0]       req_strb_i;
    logic [1:0]       req_size_i;
    logic             resp_valid_o, resp_ready_i, resp_hit_o;
    logic [31:0]      resp_rdata_o;
    lsu_excp_e        resp_excp_o;
    logic             fill_valid_i;
    logic [3:0]       fill_set_i;
    logic [1:0]       fill_way_i;
    logic [23:0]      fill_tag_i;
    logic [3:0][31:0] fill_data_i;
    logic             tlb_we_i, tlb_v_i, tlb_d_i;
    logic [2:0]       tlb_idx_i;
    logic [19:0]      tlb_vpn_i, tlb_ppn_i;

    row_t        rows [MAX_ROWS];
    int          n_rows, errors, checks;
    int          exp_q [$]; // row index of each accepted request, oldest first
    logic        done, abort;
    logic [31:0] lcg_state;

    lsu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input op_e kind, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] size, input logic exp_hit,
                           input lsu_excp_e exp_excp, input logic [31:0] exp_rdata);
        rows[n_rows] = {kind, addr, data, strb, size, exp_hit, exp_excp, exp_rdata};
        n_rows++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // columns: kind, addr, data, strb, size, hit, excp, rdata
    // tlb rows: vpn in addr, ppn in data, index in strb, {d, v} in size; fill rows: way in size
    task automatic build_table();
        add_row(OP_TLB,    32'h0001_0000, 32'h0002_0000, 4'd0, 2'b11, 0, EXCP_NONE, 0);
        add_row(OP_TLB,    32'h0001_1000, 32'h0002_1000, 4'd1, 2'b01, 0, EXCP_NONE, 0);
        add_row(OP_TLB,    32'h0001_3000, 32'h0002_3000, 4'd2, 2'b10, 0, EXCP_NONE, 0);
        add_row(OP_FILL,   32'h0002_0040, 32'h1111_0000, 4'h0, 2'd1,  0, EXCP_NONE, 0);
        add_row(OP_FILL,   32'h0002_1080, 32'h2222_0000, 4'h0, 2'd2,  0, EXCP_NONE, 0);
        add_row(OP_IDLE,   32'h0,         32'h0,         4'h0, 2'd0,  0, EXCP_NONE, 0);
        // plain hits, then a set never filled
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_0001);
        add_row(OP_LOAD,   32'h0001_0048, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_0002);
        add_row(OP_LOAD,   32'h0001_004D, 32'h0, 4'h0, 2'd0, 1, EXCP_NONE, 32'h1111_0003);
        add_row(OP_LOAD,   32'h0001_1088, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h2222_0002);
        add_row(OP_LOAD,   32'h0001_0050, 32'h0, 4'h0, 2'd2, 0, EXCP_NONE, 32'h0);
        // exceptions, ale ahead of tlbr ahead of pme
        add_row(OP_LOAD,   32'h0001_0042, 32'h0, 4'h0, 2'd2, 0, EXCP_ALE,  32'h0);
        add_row(OP_LOAD,   32'h0001_2040, 32'h0, 4'h0, 2'd2, 0, EXCP_TLBR, 32'h0);
        add_row(OP_LOAD,   32'h0001_3040, 32'h0, 4'h0, 2'd2, 0, EXCP_TLBR, 32'h0);
        add_row(OP_STORE,  32'h0001_1080, 32'h0, 4'hF, 2'd2, 0, EXCP_PME,  32'h0);
        add_row(OP_STORE,  32'h0001_2042, 32'h0, 4'hF, 2'd2, 0, EXCP_ALE,  32'h0);
        add_row(OP_STORE,  32'h0001_1081, 32'h0, 4'h6, 2'd1, 0, EXCP_ALE,  32'h0);
        add_row(OP_STORE,  32'h0001_0054, 32'h0, 4'hF, 2'd2, 0, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0054, 32'h0, 4'h0, 2'd2, 0, EXCP_NONE, 32'h0);
        // buffered stores merge over the cache word
        add_row(OP_STORE,  32'h0001_0044, 32'hAABB_CCDD, 4'h3, 2'd1, 1, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_CCDD);
        add_row(OP_STORE,  32'h0001_0046, 32'h5566_0000, 4'hC, 2'd1, 1, EXCP_NONE, 32'h0);
        add_row(OP_STORE,  32'h0001_0044, 32'h0000_0077, 4'h1, 2'd0, 1, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h5566_CC77);
        // drain to the array one entry at a time
        add_row(OP_COMMIT, 32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h5566_CC77);
        add_row(OP_COMMIT, 32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0);
        add_row(OP_COMMIT, 32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h5566_CC77);
        add_row(OP_COMMIT, 32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0); // buffer empty
        add_row(OP_LOAD,   32'h0001_0044, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h5566_CC77);
        add_row(OP_LOAD,   32'h0001_0040, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_0000);
        // flush drops an uncommitted store
        add_row(OP_STORE,  32'h0001_0048, 32'hDEAD_BEEF, 4'hF, 2'd2, 1, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0048, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'hDEAD_BEEF);
        add_row(OP_FLUSH,  32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0048, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_0002);
        add_row(OP_COMMIT, 32'h0, 32'h0, 4'h0, 2'd0, 0, EXCP_NONE, 32'h0);
        add_row(OP_LOAD,   32'h0001_0048, 32'h0, 4'h0, 2'd2, 1, EXCP_NONE, 32'h1111_0002);
    endtask

    task automatic send_request(input int i);
        int   waited;
        logic taken;
        waited      = 0;
        taken       = 1'b0;
        req_valid_i = 1'b1;
        req_vaddr_i = rows[i].addr;
        req_wdata_i = rows[i].data;
        req_strb_i  = (rows[i].kind == OP_STORE) ? rows[i].strb : 4'h0;
        req_size_i  = rows[i].size;
        while (!taken && waited < LIMIT) begin
            #80;
            taken = req_ready_o; // transfer on the coming edge
            next_cycle();
            waited++;
        end
        req_valid_i = 1'b0;
        if (taken) begin
            exp_q.push_back(i);
        end else begin
            $display("Error: request of row %0d not accepted within %0d cycles", i, LIMIT);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d responses still missing after %0d cycles", exp_q.size(), LIMIT);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic apply_control(input int i);
        wait_drained();
        case (rows[i].kind)
            OP_TLB: begin
                tlb_we_i  = 1'b1;
                tlb_idx_i = rows[i].strb[2:0];
                tlb_vpn_i = rows[i].addr[31:12];
                tlb_ppn_i = rows[i].data[31:12];
                tlb_v_i   = rows[i].size[0];
                tlb_d_i   = rows[i].size[1];
            end
            OP_FILL: begin
                fill_valid_i = 1'b1;
                fill_set_i   = rows[i].addr[7:4];
                fill_tag_i   = rows[i].addr[31:8];
                fill_way_i   = rows[i].size;
                fill_data_i  = {rows[i].data + 32'd3, rows[i].data + 32'd2,
                                rows[i].data + 32'd1, rows[i].data};
            end
            OP_COMMIT: commit_i = 1'b1;
            OP_FLUSH:  flush_i  = 1'b1;
            default: ;
        endcase
        next_cycle();
        tlb_we_i     = 1'b0;
        fill_valid_i = 1'b0;
        commit_i     = 1'b0;
        flush_i      = 1'b0;
    endtask

    task automatic run_table();
        for (int i = 0; i < n_rows && !abort; i++) begin
            if (rows[i].kind == OP_LOAD || rows[i].kind == OP_STORE) send_request(i);
            else apply_control(i);
        end
        if (!abort) wait_drained();
        done = 1'b1;
    endtask

    task automatic check_response(input int i);
        compare_value("resp_hit_o", resp_hit_o, rows[i].exp_hit);
        compare_value("resp_excp_o", resp_excp_o, rows[i].exp_excp);
        if (rows[i].kind == OP_LOAD && rows[i].exp_hit) // store and miss data are undefined
            compare_value("resp_rdata_o", resp_rdata_o, rows[i].exp_rdata);
    endtask

    task automatic collect_responses();
        logic        held;
        logic [31:0] held_rdata;
        logic        held_hit;
        lsu_excp_e   held_excp;
        logic [31:0] rnd;
        int          cycles;
        held   = 1'b0;
        cycles = 0;
        while (!done && cycles < MAX_CYCLES) begin
            next_cycle();
            rnd          = next_rand();
            resp_ready_i = rnd[16];
            #80;
            if (held) begin // stalled last cycle, must be unchanged
                compare_value("resp_valid_o", resp_valid_o, 1'b1);
                compare_value("resp_rdata_o", resp_rdata_o, held_rdata);
                compare_value("resp_hit_o", resp_hit_o, held_hit);
                compare_value("resp_excp_o", resp_excp_o, held_excp);
            end
            held       = resp_valid_o && !resp_ready_i;
            held_rdata = resp_rdata_o;
            held_hit   = resp_hit_o;
            held_excp  = resp_excp_o;
            if (resp_valid_o && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Error: response at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    check_response(exp_q.pop_front());
                end
            end
            cycles++;
        end
        if (!done) begin
            $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
            errors++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        flush_i      = 1'b0;
        commit_i     = 1'b0;
        req_valid_i  = 1'b0;
        req_vaddr_i  = '0;
        req_wdata_i  = '0;
        req_strb_i   = '0;
        req_size_i   = '0;
        resp_ready_i = 1'b0;
        fill_valid_i = 1'b0;
        fill_set_i   = '0;
        fill_way_i   = '0;
        fill_tag_i   = '0;
        fill_data_i  = '0;
        tlb_we_i     = 1'b0;
        tlb_idx_i    = '0;
        tlb_vpn_i    = '0;
        tlb_ppn_i    = '0;
        tlb_v_i      = 1'b0;
        tlb_d_i      = 1'b0;
        errors       = 0;
        checks       = 0;
        n_rows       = 0;
        done         = 1'b0;
        abort        = 1'b0;
        lcg_state    = 32'd99;
        build_table();
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        compare_value("req_ready_o", req_ready_o, 1'b1);
        compare_value("resp_valid_o", resp_valid_o, 1'b0);
        fork
            run_table();
            collect_responses();
        join
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_stage_if.sv
src/lsu_addr_trans.sv
src/lsu_cache_array.sv
src/lsu_m1_stage.sv
src/lsu_store_buffer.sv
src/lsu_m2_stage.sv
src/lsu_top.sv
tb/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_pipe

export_include_dirs:
  - src

sources:
  - files:
      - src/lsu_pkg.sv
      - src/lsu_stage_if.sv
      - src/lsu_addr_trans.sv
      - src/lsu_cache_array.sv
      - src/lsu_m1_stage.sv
      - src/lsu_store_buffer.sv
      - src/lsu_m2_stage.sv
      - src/lsu_top.sv
  - target: test
    files:
      - tb/lsu_tb.sv
